// ==== src/fetch_config.svh ====
// fetch front end configuration
// widths, reset pc, memory and queue sizing for the static-predictor fetch unit

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// instruction and address width
`define XLEN        32

// first fetch address once fetch_en goes high
`define RESET_PC    32'h0000_0000

// imem word address width, 64 words
`define IMEM_AW     6

// fetch queue entries
`define FQ_DEPTH    4

// width of the queue count and free-slot count, holds 0..FQ_DEPTH
`define FQ_CNT_W    3

`endif

// ==== src/fetch_pkg.sv ====
// fetch package
// opcode encoding and the structs passed between the fetch blocks

`include "fetch_config.svh"

package fetch_pkg;

    // major opcodes the predictor tells apart
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,                   // beq/bne/blt/bge/bltu/bgeu
        OP_JAL    = 7'b1101111,                   // pc-relative jump
        OP_JALR   = 7'b1100111,                   // register jump, target unknown here
        OP_OTHER  = 7'b0000000                    // anything else
    } opcode_e;

    // one fetched instruction with its prediction
    typedef struct packed {
        logic [`XLEN-1:0] pc;                     // address of inst
        logic [`XLEN-1:0] inst;                   // raw instruction word
        logic             pred_taken;             // predictor said taken
        logic [`XLEN-1:0] pred_target;            // next pc as predicted
    } fetch_pkt_t;

    // branch resolution from a later stage
    typedef struct packed {
        logic             valid;                  // one-cycle pulse
        logic [`XLEN-1:0] pc;                     // restart address
    } redirect_t;

    // imem load port
    typedef struct packed {
        logic               valid;                // write this cycle
        logic [`IMEM_AW-1:0] addr;                // word address
        logic [`XLEN-1:0]   data;                 // word to store
    } imem_wr_t;

    // predictor result
    typedef struct packed {
        logic             taken;                  // predicted taken
        logic [`XLEN-1:0] target;                 // taken target or pc+4
    } bp_result_t;

endpackage

// ==== src/static_bp.sv ====
// static branch predictor
// backward conditional branches and jal are predicted taken,
// jalr and everything else fall through to pc+4

`timescale 1ns/1ps

`include "fetch_config.svh"

module static_bp (
    input  logic [`XLEN-1:0]      inst_i,        // fetched word
    input  logic [`XLEN-1:0]      pc_i,          // its address
    output fetch_pkg::bp_result_t bp_o           // prediction and next pc
);
    import fetch_pkg::*;

    opcode_e          opcode;                    // decoded major opcode
    logic [`XLEN-1:0] imm_b;                     // b-type offset
    logic [`XLEN-1:0] imm_j;                     // j-type offset
    logic [`XLEN-1:0] pc_seq;                    // fall-through address

    // opcode field to enum, unknown encodings collapse to OP_OTHER
    always_comb begin
        case (inst_i[6:0])
            OP_BRANCH: opcode = OP_BRANCH;
            OP_JAL:    opcode = OP_JAL;
            OP_JALR:   opcode = OP_JALR;
            default:   opcode = OP_OTHER;
        endcase
    end

    // imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign imm_b = {{(`XLEN-12){inst_i[31]}},
                    inst_i[7],
                    inst_i[30:25],
                    inst_i[11:8],
                    1'b0};

    // imm[20|10:1|11|19:12] in 31:12
    assign imm_j = {{(`XLEN-20){inst_i[31]}},
                    inst_i[19:12],
                    inst_i[20],
                    inst_i[30:21],
                    1'b0};

    assign pc_seq = pc_i + `XLEN'd4;

    always_comb begin
        bp_o.taken  = 1'b0;                      // default: fall through
        bp_o.target = pc_seq;
        case (opcode)
            OP_BRANCH: begin
                if (imm_b[`XLEN-1]) begin        // negative offset, loop back edge
                    bp_o.taken  = 1'b1;
                    bp_o.target = pc_i + imm_b;
                end
            end
            OP_JAL: begin                        // always taken, target is static
                bp_o.taken  = 1'b1;
                bp_o.target = pc_i + imm_j;
            end
            OP_JALR: begin
                // target depends on a register, keep pc+4 and let
                // the back end redirect
                bp_o.taken  = 1'b0;
                bp_o.target = pc_seq;
            end
            default: begin
                bp_o.taken  = 1'b0;
                bp_o.target = pc_seq;
            end
        endcase
    end

endmodule

// ==== src/fetch_pc_gen.sv ====
// fetch pc generator
// issues imem reads under queue credit, follows taken predictions and
// redirects, and squashes reads that turn out to be wrong-path

`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_pc_gen (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  fetch_en_i,     // run fetch while high
    input  fetch_pkg::redirect_t  redirect_i,     // flush and restart
    input  logic [`FQ_CNT_W-1:0]  fq_free_i,      // free queue slots
    output logic                  rd_en_o,        // imem read strobe
    output logic [`IMEM_AW-1:0]   rd_addr_o,      // imem word address
    input  logic [`XLEN-1:0]      rd_data_i,      // word of last cycle's read
    output logic [`XLEN-1:0]      ret_pc_o,       // pc of the returning word
    input  fetch_pkg::bp_result_t bp_i,           // prediction on returning word
    output logic                  push_o,         // enqueue strobe
    output fetch_pkg::fetch_pkt_t push_pkt_o      // packet to enqueue
);

    logic [`XLEN-1:0] pc_q;                       // next address to fetch
    logic [`XLEN-1:0] pc_d;
    logic             inflight_q;                 // read issued last cycle
    logic [`XLEN-1:0] inflight_pc_q;              // its address
    logic             kill_q;                     // that read is wrong-path
    logic             live;                       // returning word is good
    logic             taken;                      // good word predicted taken
    logic             credit;                     // room for one more read
    logic             issue;                      // read this cycle

    assign live  = inflight_q & ~kill_q;
    assign taken = live & bp_i.taken;

    // slots must cover the read already in flight plus this one
    assign credit = fq_free_i > {{(`FQ_CNT_W-1){1'b0}}, inflight_q};
    assign issue  = fetch_en_i & credit;

    assign rd_en_o   = issue;
    assign rd_addr_o = pc_q[`IMEM_AW+1:2];        // byte pc to word index
    assign ret_pc_o  = inflight_pc_q;

    // the queue flushes on a redirect edge, nothing old gets in
    assign push_o     = live & ~redirect_i.valid;
    assign push_pkt_o = '{pc:          inflight_pc_q,
                          inst:        rd_data_i,
                          pred_taken:  bp_i.taken,
                          pred_target: bp_i.target};

    // redirect beats prediction beats sequential
    always_comb begin
        if (redirect_i.valid) begin
            pc_d = redirect_i.pc;
        end else if (taken) begin
            pc_d = bp_i.target;                   // costs one bubble
        end else if (issue) begin
            pc_d = pc_q + `XLEN'd4;
        end else begin
            pc_d = pc_q;                          // stalled, hold
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= `RESET_PC;
            inflight_q <= 1'b0;
            kill_q     <= 1'b0;
        end else begin
            pc_q       <= pc_d;
            inflight_q <= issue;
            kill_q     <= issue & (redirect_i.valid | taken); // seq read now stale
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            inflight_pc_q <= pc_q;                // pairs with next cycle's data
        end
    end

endmodule

// ==== src/inst_mem.sv ====
// instruction memory
// word-addressed array with a load port and a registered read port

`timescale 1ns/1ps

`include "fetch_config.svh"

module inst_mem (
    input  logic                 clk,
    input  fetch_pkg::imem_wr_t  imem_wr_i,       // program load, one word per cycle
    input  logic                 rd_en_i,         // read strobe
    input  logic [`IMEM_AW-1:0]  rd_addr_i,       // word address
    output logic [`XLEN-1:0]     rd_data_o        // valid the cycle after rd_en_i
);

    localparam int DEPTH = 2 ** `IMEM_AW;

    logic [`XLEN-1:0] mem [DEPTH];                // program storage
    logic [`XLEN-1:0] rd_data_q;                  // read register

    // load port
    always_ff @(posedge clk) begin
        if (imem_wr_i.valid) begin
            mem[imem_wr_i.addr] <= imem_wr_i.data;
        end
    end

    // sync read, output holds while rd_en_i is low
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

// ==== src/fetch_queue.sv ====
// fetch queue
// circular buffer of fetch packets, valid/ready toward decode,
// flushed on redirect, reports free slots back to the pc generator

`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_queue (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  flush_i,        // drop all entries
    input  logic                  push_i,         // credit guarantees a slot
    input  fetch_pkg::fetch_pkt_t push_pkt_i,     // incoming packet
    output logic [`FQ_CNT_W-1:0]  free_o,         // empty slots
    output fetch_pkg::fetch_pkt_t pkt_o,          // head packet
    output logic                  valid_o,        // head is valid
    input  logic                  ready_i         // decode takes the head
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(`FQ_DEPTH);

    fetch_pkt_t           mem_q [`FQ_DEPTH];      // entry storage
    logic [PTR_W-1:0]     wr_ptr_q;               // next slot to fill
    logic [PTR_W-1:0]     rd_ptr_q;               // head slot
    logic [`FQ_CNT_W-1:0] count_q;                // occupied slots
    logic                 pop;

    // wrap at depth, works for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(`FQ_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign valid_o = (count_q != '0);
    assign pkt_o   = mem_q[rd_ptr_q];
    assign pop     = valid_o & ready_i;
    assign free_o  = `FQ_CNT_W'(`FQ_DEPTH) - count_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin               // redirect wins over push and pop
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;      // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && !flush_i) begin
            mem_q[wr_ptr_q] <= push_pkt_i;
        end
    end

endmodule

// ==== src/fetch_top.sv ====
// fetch front end top
// pc generator, instruction memory, static predictor and fetch queue

`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_top (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  fetch_en_i,     // level, fetch runs while high
    input  fetch_pkg::imem_wr_t   imem_wr_i,      // program load while fetch is off
    input  fetch_pkg::redirect_t  redirect_i,     // one-cycle restart pulse
    output fetch_pkg::fetch_pkt_t fetch_pkt_o,    // packet to decode
    output logic                  fetch_valid_o,
    input  logic                  fetch_ready_i
);
    import fetch_pkg::*;

    logic                 rd_en;                  // pc_gen -> imem
    logic [`IMEM_AW-1:0]  rd_addr;
    logic [`XLEN-1:0]     rd_data;                // imem -> pc_gen, bp
    logic [`XLEN-1:0]     ret_pc;                 // pc of rd_data
    bp_result_t           bp;                     // bp -> pc_gen
    logic                 push;                   // pc_gen -> queue
    fetch_pkt_t           push_pkt;
    logic [`FQ_CNT_W-1:0] fq_free;                // queue -> pc_gen credit

    fetch_pc_gen u_pc_gen (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .fetch_en_i (fetch_en_i),
        .redirect_i (redirect_i),
        .fq_free_i  (fq_free),
        .rd_en_o    (rd_en),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data),
        .ret_pc_o   (ret_pc),
        .bp_i       (bp),
        .push_o     (push),
        .push_pkt_o (push_pkt)
    );

    inst_mem u_imem (
        .clk       (clk),
        .imem_wr_i (imem_wr_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    static_bp u_bp (
        .inst_i (rd_data),
        .pc_i   (ret_pc),
        .bp_o   (bp)
    );

    fetch_queue u_fq (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (redirect_i.valid),           // redirect empties the queue
        .push_i     (push),
        .push_pkt_i (push_pkt),
        .free_o     (fq_free),
        .pkt_o      (fetch_pkt_o),
        .valid_o    (fetch_valid_o),
        .ready_i    (fetch_ready_i)
    );

endmodule

// ==== testbench/fetch_checker.sv ====
// fetch stream checker
// models the predicted fetch stream from its own program copy and
// compares every accepted packet, also watches valid/ready hold rules

`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_checker (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  fetch_en_i,
    input  fetch_pkg::redirect_t  redirect_i,     // restart pulse seen by the DUT
    input  fetch_pkg::fetch_pkt_t pkt_i,          // DUT output packet
    input  logic                  valid_i,
    input  logic                  ready_i,
    output int                    accepted_o,     // packets taken by decode
    output int                    errors_o        // mismatches so far
);
    import fetch_pkg::*;

    logic [`XLEN-1:0] prog [2**`IMEM_AW];         // program copy, word indexed
    logic [`XLEN-1:0] exp_pc;                     // pc of the next accepted packet
    fetch_pkt_t       exp_pkt;
    fetch_pkt_t       held_pkt;                   // packet stalled last edge
    logic             waiting = 1'b0;             // valid high, ready low last edge
    int               accepted = 0;
    int               errors = 0;

    assign accepted_o = accepted;
    assign errors_o   = errors;

    task automatic load_word(input logic [`IMEM_AW-1:0] addr, input logic [`XLEN-1:0] inst);
        prog[addr] = inst;
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] exp,
                               input logic [`XLEN-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_packet(input string where, input fetch_pkt_t exp,
                                  input fetch_pkt_t act);
        check_value({where, ".pc"}, exp.pc, act.pc);
        check_value({where, ".inst"}, exp.inst, act.inst);
        check_value({where, ".pred_taken"}, 32'(exp.pred_taken), 32'(act.pred_taken));
        check_value({where, ".pred_target"}, exp.pred_target, act.pred_target);
    endtask

    // rule: backward branch and jal taken, everything else goes to pc+4
    function automatic fetch_pkt_t expected_packet(input logic [`XLEN-1:0] pc);
        fetch_pkt_t       p;
        logic [`XLEN-1:0] inst;
        logic [12:0]      boff;                   // b-type offset, bit 0 is zero
        logic [20:0]      joff;                   // j-type offset
        inst = prog[pc[`IMEM_AW+1:2]];
        boff = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        joff = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        p.pc          = pc;
        p.inst        = inst;
        p.pred_taken  = 1'b0;
        p.pred_target = pc + 32'd4;
        if (inst[6:0] == OP_JAL) begin
            p.pred_taken  = 1'b1;
            p.pred_target = pc + {{(`XLEN-21){joff[20]}}, joff};
        end else if (inst[6:0] == OP_BRANCH && boff[12]) begin  // negative offset only
            p.pred_taken  = 1'b1;
            p.pred_target = pc + {{(`XLEN-13){boff[12]}}, boff};
        end
        return p;
    endfunction

    always @(posedge clk) begin
        if (!arst_n_i) begin
            check_value("fetch_valid_o", 32'd0, 32'(valid_i));   // quiet in reset
            exp_pc  = `RESET_PC;
            waiting = 1'b0;
        end else begin
            if (!fetch_en_i) begin
                check_value("fetch_valid_o", 32'd0, 32'(valid_i));
            end
            if (waiting) begin                    // stalled packet must stay put
                check_value("fetch_valid_o", 32'd1, 32'(valid_i));
                compare_packet("fetch_pkt_o(held)", held_pkt, pkt_i);
            end
            if (valid_i && ready_i) begin
                exp_pkt = expected_packet(exp_pc);
                compare_packet("fetch_pkt_o", exp_pkt, pkt_i);
                exp_pc = exp_pkt.pred_target;     // model only, not the DUT
                accepted++;
            end
            if (redirect_i.valid) begin
                exp_pc = redirect_i.pc;           // queued old path is gone
            end
            waiting  = valid_i && !ready_i && !redirect_i.valid;
            held_pkt = pkt_i;
        end
    end

endmodule

// ==== testbench/tb_fetch.sv ====
// fetch front end testbench
// loads a looping program, runs fetch with redirects and back-pressure

`timescale 1ns/1ps

`include "fetch_config.svh"

module tb_fetch;
    import fetch_pkg::*;

    localparam int PROG_ROWS  = 17;
    localparam int REDIR_ROWS = 3;
    localparam int LAST_PKT   = 120;              // run ends at this accepted count
    localparam int WAIT_LIMIT = 1000;             // cycles per wait

    typedef struct packed {
        logic [`IMEM_AW-1:0] addr;                // word address
        logic [`XLEN-1:0]    inst;
    } prog_row_t;

    typedef struct packed {
        int               after_pkt;              // fire once this many accepted
        logic [`XLEN-1:0] target;
    } redir_row_t;

    prog_row_t prog_tbl [PROG_ROWS] = '{
        '{6'h00, 32'h0010_0093},                  // addi x1,x0,1
        '{6'h01, 32'h0020_0113},                  // addi x2,x0,2
        '{6'h02, 32'h0000_0463},                  // forward beq +8 falls through
        '{6'h03, 32'h0100_006f},                  // jal +16 to 0x1c
        '{6'h04, 32'h0030_0193},
        '{6'h05, 32'h0040_0213},
        '{6'h06, 32'h0050_0293},
        '{6'h07, 32'h0012_8293},                  // jal lands here
        '{6'h08, 32'h0000_8067},                  // jalr falls through
        '{6'h09, 32'h0010_8093},
        '{6'h0a, 32'hfe20_9ce3},                  // bne -8 loops back to 0x20
        '{6'h0b, 32'h0000_0013},                  // wrong-path slot
        '{6'h0c, 32'h00a0_0313},                  // second loop at 0x30
        '{6'h0d, 32'h0013_0313},
        '{6'h0e, 32'h0000_0013},
        '{6'h0f, 32'hfe10_4ae3},                  // blt -12 back to 0x30
        '{6'h10, 32'h0000_0013}
    };

    redir_row_t redir_tbl [REDIR_ROWS] = '{
        '{20, 32'h0000_0030},                     // leave first loop
        '{50, 32'h0000_0010},                     // back into straight code
        '{80, 32'h0000_0000}                      // restart from the top
    };

    logic       clk;
    logic       arst_n;
    logic       fetch_en;
    imem_wr_t   imem_wr;
    redirect_t  redirect;
    fetch_pkt_t fetch_pkt;
    logic       fetch_valid;
    logic       fetch_ready;
    logic       random_ready;                     // ready from $urandom when set
    logic       timed_out;
    int         accepted;
    int         errors;

    fetch_top UUT (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .fetch_en_i    (fetch_en),
        .imem_wr_i     (imem_wr),
        .redirect_i    (redirect),
        .fetch_pkt_o   (fetch_pkt),
        .fetch_valid_o (fetch_valid),
        .fetch_ready_i (fetch_ready)
    );

    fetch_checker u_checker (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .fetch_en_i (fetch_en),
        .redirect_i (redirect),
        .pkt_i      (fetch_pkt),
        .valid_i    (fetch_valid),
        .ready_i    (fetch_ready),
        .accepted_o (accepted),
        .errors_o   (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // decode-side ready driven on the falling edge
    initial begin
        fetch_ready = 1'b0;
        void'($urandom(32'h2d1c_8233));
        forever begin
            @(negedge clk);
            if (random_ready) begin
                fetch_ready = (($urandom % 4) != 0);
            end else begin
                fetch_ready = 1'b1;
            end
        end
    end

    task automatic wait_for_packets(input int count);
        int cycles;
        cycles = 0;
        while (accepted < count && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (accepted < count) begin
            timed_out = 1'b1;
            $display("timeout: packet %0d not reached within %0d cycles, %0d accepted",
                     count, WAIT_LIMIT, accepted);
        end
    endtask

    initial begin
        arst_n       = 1'b0;
        fetch_en     = 1'b0;
        imem_wr      = '0;
        redirect     = '0;
        random_ready = 1'b0;
        timed_out    = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < PROG_ROWS; i++) begin       // load while fetch is off
            imem_wr = '{valid: 1'b1, addr: prog_tbl[i].addr, data: prog_tbl[i].inst};
            u_checker.load_word(prog_tbl[i].addr, prog_tbl[i].inst);
            @(negedge clk);
        end
        imem_wr = '0;
        repeat (3) @(negedge clk);                      // idle cycles with valid low
        fetch_en = 1'b1;
        for (int i = 0; i < REDIR_ROWS; i++) begin
            if (!timed_out) begin
                wait_for_packets(redir_tbl[i].after_pkt);
            end
            if (!timed_out) begin
                redirect = '{valid: 1'b1, pc: redir_tbl[i].target};
                @(negedge clk);
                redirect     = '0;
                random_ready <= (i % 2 == 0);           // alternate ready phases
            end
        end
        if (!timed_out) begin
            wait_for_packets(LAST_PKT);
        end
        $display("run done: %0d packets accepted, %0d errors, %0d timeouts",
                 accepted, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+src
src/fetch_pkg.sv
src/static_bp.sv
src/fetch_pc_gen.sv
src/inst_mem.sv
src/fetch_queue.sv
src/fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f list.f --top-module tb_fetch -o sim_fetch > build.log 2>&1 \
    && ./obj_dir/sim_fetch > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log \
    && { echo "failure found in sim.log"; exit 1; } \
    || { echo "no failure found in sim.log"; exit 0; }
